// ==== logic/cmPkg.sv ====
package cmPkg;

  // Code memory address, word and host data widths
  typedef logic [13:0] cmAddrT;
  typedef logic [23:0] cmWordT;
  typedef logic [15:0] hostWordT;

  // Only 0 to 7 select an overlay bank
  typedef logic [3:0] ovlIdxT;

  // Bit 0 is the base bank, bits 1 to 8 are overlays 0 to 7
  typedef logic [8:0] bankSelT;

  localparam int NUM_OVL = 8;

  typedef enum logic [1:0] {
    LOAD_HIGH = 2'd0,  // Store upper 16 bits of the next word
    WRITE_LOW = 2'd1,  // Commit stored high part with low 8 bits
    READ      = 2'd2   // Fetch full 24-bit word
  } hostOpT;

  typedef struct packed {
    hostOpT   op;
    cmAddrT   addr;
    hostWordT data;
  } hostReqT;

  typedef struct packed {
    cmAddrT addr;
    ovlIdxT ovl;       // Overlay used by this boot transfer
    cmWordT data;
  } bootReqT;

  // One memory cycle as issued by the access controller
  typedef struct packed {
    cmAddrT addr;
    logic   write;
    cmWordT wdata;
  } memCycT;

endpackage

// ==== logic/hostWordAssembler.sv ====
`timescale 1ns/1ps

module hostWordAssembler (
  input  logic           DSPCLK,
  input  logic           rstN,
  input  cmPkg::hostReqT hostReq,
  input  logic           asmLoad,
  output cmPkg::cmWordT  hostWord
);
  import cmPkg::*;

  hostWordT highHalf;  // Upper 16 bits held for the next WRITE_LOW

  always_ff @(posedge DSPCLK or negedge rstN)
  begin
    if (!rstN)
      highHalf <= '0;
    else if (asmLoad)
      highHalf <= hostReq.data;
  end

  // Low byte is taken straight from the committing request
  assign hostWord = {highHalf, hostReq.data[7:0]};

endmodule

// ==== logic/overlaySelect.sv ====
`timescale 1ns/1ps

module overlaySelect (
  input  logic          DSPCLK,
  input  logic          rstN,
  input  cmPkg::ovlIdxT coreOvl,
  input  cmPkg::ovlIdxT bootOvl,
  input  logic          bootGrant,
  output cmPkg::ovlIdxT activeOvl
);
  import cmPkg::*;

  ovlIdxT bootOvlHeld;

  // Tracks the request until the grant edge, then freezes for the boot cycle
  always_ff @(posedge DSPCLK or negedge rstN)
  begin
    if (!rstN)
      bootOvlHeld <= '0;
    else if (!bootGrant)
      bootOvlHeld <= bootOvl;
  end

  assign activeOvl = bootGrant ? bootOvlHeld : coreOvl;  // Core register outside boot

endmodule

// ==== logic/bankDecode.sv ====
`timescale 1ns/1ps

module bankDecode #(
  parameter int OVL_AW = 12
) (
  input  logic           DSPCLK,
  input  logic           rstN,
  input  cmPkg::cmAddrT  addr,
  input  cmPkg::ovlIdxT  activeOvl,
  input  logic           pmBoundarySel,
  input  logic           memGo,
  output cmPkg::bankSelT bankSel,
  output cmPkg::bankSelT bankOe,
  output logic [12:0]    bankOffset
);
  import cmPkg::*;

  logic baseRgn;
  logic ovlRgn;

  // pmBoundarySel high selects the 4K split
  assign baseRgn = pmBoundarySel ? (addr[13:12] == 2'b00) : (addr[13] == 1'b0);
  assign ovlRgn  = pmBoundarySel ? (addr[13:12] == 2'b01) : (addr[13:12] == 2'b10);

  always_comb
  begin
    bankSel    = '0;
    bankSel[0] = baseRgn && memGo;
    // Index 8 and above leaves every overlay select low
    for (int i = 0; i < NUM_OVL; i++)
      bankSel[i + 1] = ovlRgn && memGo && (activeOvl == ovlIdxT'(i));
  end

  // Read enables follow the selects by one cycle
  always_ff @(posedge DSPCLK or negedge rstN)
  begin
    if (!rstN)
      bankOe <= '0;
    else
      bankOe <= bankSel;
  end

  always_comb
  begin
    if (ovlRgn)
      bankOffset = 13'(addr[OVL_AW-1:0]);
    else if (pmBoundarySel)
      bankOffset = {1'b0, addr[11:0]};   // 4K base bank
    else
      bankOffset = addr[12:0];           // 8K base bank
  end

endmodule

// ==== logic/codeMemBanks.sv ====
`timescale 1ns/1ps

module codeMemBanks #(
  parameter int OVL_AW = 12
) (
  input  logic           DSPCLK,
  input  cmPkg::bankSelT bankSel,
  input  cmPkg::bankSelT bankOe,
  input  logic [12:0]    bankOffset,
  input  logic           write,
  input  cmPkg::cmWordT  wdata,
  output cmPkg::cmWordT  rdata
);
  import cmPkg::*;

  localparam int BASE_DEPTH = 8192;
  localparam int OVL_DEPTH  = 1 << OVL_AW;

  cmWordT            baseMem [BASE_DEPTH];
  cmWordT            ovlMem  [NUM_OVL][OVL_DEPTH];
  logic [OVL_AW-1:0] ovlOffset;

  assign ovlOffset = bankOffset[OVL_AW-1:0];

  always_ff @(posedge DSPCLK)
  begin
    if (write && bankSel[0])
      baseMem[bankOffset] <= wdata;
    for (int i = 0; i < NUM_OVL; i++)
    begin
      if (write && bankSel[i + 1])
        ovlMem[i][ovlOffset] <= wdata;
    end
  end

  // At most one enable is set, zero when no bank is read
  always_ff @(posedge DSPCLK)
  begin
    rdata <= '0;
    if (bankOe[0])
      rdata <= baseMem[bankOffset];
    for (int i = 0; i < NUM_OVL; i++)
    begin
      if (bankOe[i + 1])
        rdata <= ovlMem[i][ovlOffset];
    end
  end

endmodule

// ==== logic/cmAccessCtrl.sv ====
`timescale 1ns/1ps

module cmAccessCtrl (
  input  logic           DSPCLK,
  input  logic           rstN,
  input  cmPkg::hostReqT hostReq,
  input  logic           hostReqValid,
  input  cmPkg::bootReqT bootReq,
  input  logic           bootReqValid,
  input  cmPkg::cmWordT  hostWord,
  input  cmPkg::cmWordT  rdata,
  output logic           hostAck,
  output logic           bootAck,
  output cmPkg::cmWordT  hostRdata,
  output cmPkg::memCycT  memCyc,
  output logic           memGo,
  output logic           bootGrant,
  output logic           asmLoad
);
  import cmPkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    READWAIT,
    CAPTURE,
    ACKHOLD,
    RELEASE
  } ctrlStateT;

  ctrlStateT state;
  ctrlStateT stateNxt;
  logic      grantValid;
  logic      hostLoad;
  logic      hostRead;

  assign grantValid = bootGrant ? bootReqValid : hostReqValid;  // Valid of the granted port
  assign hostLoad   = !bootGrant && (hostReq.op == LOAD_HIGH);
  assign hostRead   = !bootGrant && (hostReq.op == READ);

  always_comb
  begin
    stateNxt = state;
    case (state)
      IDLE:
        if (bootReqValid || hostReqValid)
          stateNxt = ISSUE;
      ISSUE:
        stateNxt = hostRead ? READWAIT : ACKHOLD;
      READWAIT:
        stateNxt = CAPTURE;      // Bank output enable active here
      CAPTURE:
        stateNxt = ACKHOLD;      // Memory read data valid here
      ACKHOLD:
        if (!grantValid)
          stateNxt = RELEASE;
      RELEASE:
        stateNxt = IDLE;
      default:
        stateNxt = IDLE;
    endcase
  end

  always_ff @(posedge DSPCLK or negedge rstN)
  begin
    if (!rstN)
    begin
      state     <= IDLE;
      bootGrant <= 1'b0;
    end
    else
    begin
      state <= stateNxt;
      if (state == IDLE)
        bootGrant <= bootReqValid;  // Boot wins when both are pending
      else if (state == RELEASE)
        bootGrant <= 1'b0;
    end
  end

  // Memory cycle from the granted requester
  always_comb
  begin
    if (bootGrant)
    begin
      memCyc.addr  = bootReq.addr;
      memCyc.write = 1'b1;           // Boot only writes
      memCyc.wdata = bootReq.data;
    end
    else
    begin
      memCyc.addr  = hostReq.addr;
      memCyc.write = (hostReq.op == WRITE_LOW);
      memCyc.wdata = hostWord;
    end
  end

  assign memGo   = (state == ISSUE) && !hostLoad;  // LOAD_HIGH never touches memory
  assign asmLoad = (state == ISSUE) && hostLoad;
  assign hostAck = (state == ACKHOLD) && !bootGrant;
  assign bootAck = (state == ACKHOLD) && bootGrant;

  always_ff @(posedge DSPCLK)
  begin
    if (state == CAPTURE)
      hostRdata <= rdata;
  end

endmodule

// ==== logic/cmSubsystem.sv ====
`timescale 1ns/1ps

module cmSubsystem #(
  parameter int OVL_AW = 12
) (
  input  logic           DSPCLK,
  input  logic           rstN,
  input  cmPkg::hostReqT hostReq,
  input  logic           hostReqValid,
  output logic           hostAck,
  output cmPkg::cmWordT  hostRdata,
  input  cmPkg::bootReqT bootReq,
  input  logic           bootReqValid,
  output logic           bootAck,
  input  cmPkg::ovlIdxT  coreOvl,
  input  logic           pmBoundarySel,
  output cmPkg::bankSelT cmSel
);
  import cmPkg::*;

  memCycT      memCyc;
  logic        memGo;
  logic        bootGrant;
  logic        asmLoad;
  cmWordT      hostWord;
  ovlIdxT      activeOvl;
  bankSelT     bankOe;
  logic [12:0] bankOffset;
  cmWordT      rdata;

  cmAccessCtrl uAccessCtrl (
    .DSPCLK       (DSPCLK),
    .rstN         (rstN),
    .hostReq      (hostReq),
    .hostReqValid (hostReqValid),
    .bootReq      (bootReq),
    .bootReqValid (bootReqValid),
    .hostWord     (hostWord),
    .rdata        (rdata),
    .hostAck      (hostAck),
    .bootAck      (bootAck),
    .hostRdata    (hostRdata),
    .memCyc       (memCyc),
    .memGo        (memGo),
    .bootGrant    (bootGrant),
    .asmLoad      (asmLoad)
  );

  hostWordAssembler uWordAsm (
    .DSPCLK   (DSPCLK),
    .rstN     (rstN),
    .hostReq  (hostReq),
    .asmLoad  (asmLoad),
    .hostWord (hostWord)
  );

  overlaySelect uOvlSel (
    .DSPCLK    (DSPCLK),
    .rstN      (rstN),
    .coreOvl   (coreOvl),
    .bootOvl   (bootReq.ovl),
    .bootGrant (bootGrant),
    .activeOvl (activeOvl)
  );

  // Bank selects of the live cycle are also the observable cmSel
  bankDecode #(.OVL_AW(OVL_AW)) uBankDec (
    .DSPCLK        (DSPCLK),
    .rstN          (rstN),
    .addr          (memCyc.addr),
    .activeOvl     (activeOvl),
    .pmBoundarySel (pmBoundarySel),
    .memGo         (memGo),
    .bankSel       (cmSel),
    .bankOe        (bankOe),
    .bankOffset    (bankOffset)
  );

  codeMemBanks #(.OVL_AW(OVL_AW)) uMemBanks (
    .DSPCLK     (DSPCLK),
    .bankSel    (cmSel),
    .bankOe     (bankOe),
    .bankOffset (bankOffset),
    .write      (memCyc.write),
    .wdata      (memCyc.wdata),
    .rdata      (rdata)
  );

endmodule

// ==== tests/cmSubsystemTb.sv ====
`timescale 1ns/1ps

module cmSubsystemTb;
  import cmPkg::*;

  localparam int OVL_AW  = 12;
  localparam int TIMEOUT = 60;  // Cycles per handshake wait

  logic    DSPCLK;
  logic    rstN;
  hostReqT hostReq;
  logic    hostReqValid;
  logic    hostAck;
  cmWordT  hostRdata;
  bootReqT bootReq;
  logic    bootReqValid;
  logic    bootAck;
  ovlIdxT  coreOvl;
  logic    pmBoundarySel;
  bankSelT cmSel;

  integer  seed = 32'hb509;
  int      wordErrs = 0;
  int      selErrs = 0;
  int      protoErrs = 0;
  logic    prevHostAck = 1'b0;
  logic    prevBootAck = 1'b0;
  logic    prevHostValid = 1'b0;
  logic    prevBootValid = 1'b0;
  cmWordT  refMem [int];  // Key is bank * 8192 + offset

  cmSubsystem #(.OVL_AW(OVL_AW)) u_dut (.*);

  always #10 DSPCLK = ~DSPCLK;

  // Valid from the previous negedge is the one the rising clock edge saw
  always @(negedge DSPCLK)
  begin
    if (rstN && ((hostAck && !prevHostAck && !prevHostValid) ||
                 (bootAck && !prevBootAck && !prevBootValid)))
    begin
      $display("An ack rose at %0t while its valid was low", $time);
      protoErrs++;
    end
    prevHostAck   = hostAck;
    prevBootAck   = bootAck;
    prevHostValid = hostReqValid;
    prevBootValid = bootReqValid;
  end

  task automatic checkWord(input string name, input cmWordT exp, input cmWordT act);
    if (exp !== act)
    begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      wordErrs++;
    end
  endtask

  task automatic checkSel(input string name, input bankSelT exp, input bankSelT act);
    if (exp !== act)
    begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      selErrs++;
    end
  endtask

  task automatic printCounts();
    $display("Errors: %0d word, %0d select, %0d protocol", wordErrs, selErrs, protoErrs);
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout: %s", what);
    printCounts();
    $display("Test failures found");
    $finish;
  endtask

  // Reference address map, -1 when no bank is hit
  function automatic int bankOf(input cmAddrT addr, input ovlIdxT ovl, input logic mode4k);
    logic inBase;
    logic inOvl;
    inBase = mode4k ? (addr[13:12] == 2'b00) : !addr[13];
    inOvl  = mode4k ? (addr[13:12] == 2'b01) : (addr[13:12] == 2'b10);
    if (inBase)
      return 0;
    if (inOvl && int'(ovl) < NUM_OVL)
      return int'(ovl) + 1;
    return -1;
  endfunction

  function automatic int keyOf(input cmAddrT addr, input int bank, input logic mode4k);
    int offset;
    if (bank == 0)
      offset = mode4k ? int'(addr[11:0]) : int'(addr[12:0]);
    else
      offset = int'(addr[OVL_AW-1:0]);
    return bank * 8192 + offset;
  endfunction

  function automatic bankSelT selOf(input int bank);
    return (bank < 0) ? bankSelT'(0) : (bankSelT'(1) << bank);
  endfunction

  task automatic modelWrite(input cmAddrT addr, input ovlIdxT ovl, input logic mode4k,
                            input cmWordT data);
    int bank;
    bank = bankOf(addr, ovl, mode4k);
    if (bank >= 0)
      refMem[keyOf(addr, bank, mode4k)] = data;  // Dropped writes leave the model alone
  endtask

  function automatic cmWordT modelRead(input cmAddrT addr, input ovlIdxT ovl,
                                       input logic mode4k);
    int bank;
    int key;
    bank = bankOf(addr, ovl, mode4k);
    key  = keyOf(addr, bank, mode4k);
    if (bank < 0 || !refMem.exists(key))
      return '0;
    return refMem[key];
  endfunction

  // Kind 0 base region, 1 overlay region, 2 outside both
  function automatic cmAddrT pickAddr(input int kind, input logic mode4k);
    cmAddrT r;
    r = cmAddrT'($random(seed));
    if (kind == 0)
      r[13:12] = mode4k ? 2'b00 : {1'b0, r[12]};
    else if (kind == 1)
      r[13:12] = mode4k ? 2'b01 : 2'b10;
    else
      r[13:12] = mode4k ? {1'b1, r[12]} : 2'b11;
    return r;
  endfunction

  // memGo falls on the second cycle seen from an idle start
  task automatic waitAck(input bit isBoot, input bankSelT expSel, input bit chkSel,
                         output time ackAt);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT)
    begin
      @(negedge DSPCLK);
      cycles++;
      if (chkSel)
        checkSel("cmSel", (cycles == 2) ? expSel : bankSelT'(0), cmSel);
      @(posedge DSPCLK);
      #1;
      seen = isBoot ? bootAck : hostAck;
    end
    if (!seen)
      stopOnTimeout(isBoot ? "boot ack never rose" : "host ack never rose");
    else
      ackAt = $time;
  endtask

  task automatic finishXfer(input bit isBoot, input int hold);
    int   cycles;
    logic ack;
    repeat (hold)
    begin
      @(posedge DSPCLK);
      #1;
      if (!(isBoot ? bootAck : hostAck))
      begin
        $display("Ack fell at %0t while valid was still held", $time);
        protoErrs++;
      end
    end
    if (isBoot)
      bootReqValid = 1'b0;
    else
      hostReqValid = 1'b0;
    cycles = 0;
    ack    = 1'b1;
    while (ack && cycles < TIMEOUT)
    begin
      @(posedge DSPCLK);
      #1;
      cycles++;
      ack = isBoot ? bootAck : hostAck;
    end
    if (ack)
      stopOnTimeout(isBoot ? "boot ack never fell" : "host ack never fell");
    else
    begin
      if (cycles != 1)
      begin
        $display("Ack fell %0d cycles after valid dropped at %0t", cycles, $time);
        protoErrs++;
      end
      @(posedge DSPCLK);  // Lets the FSM return to idle
      #1;
    end
  endtask

  task automatic hostXfer(input hostOpT op, input cmAddrT addr, input hostWordT data,
                          input bankSelT expSel, input bit chkSel, input int hold,
                          output cmWordT rd, output time ackAt);
    hostReq.op   = op;
    hostReq.addr = addr;
    hostReq.data = data;
    hostReqValid = 1'b1;
    waitAck(1'b0, (op == LOAD_HIGH) ? bankSelT'(0) : expSel, chkSel, ackAt);
    rd = hostRdata;
    finishXfer(1'b0, hold);
  endtask

  task automatic bootXfer(input cmAddrT addr, input ovlIdxT ovl, input cmWordT data,
                          input bankSelT expSel, input bit chkSel, input int hold,
                          output time ackAt);
    bootReq.addr = addr;
    bootReq.ovl  = ovl;
    bootReq.data = data;
    bootReqValid = 1'b1;
    waitAck(1'b1, expSel, chkSel, ackAt);
    finishXfer(1'b1, hold);
  endtask

  // Upper byte of the WRITE_LOW data must be ignored by the DUT
  task automatic hostWrite(input cmAddrT addr, input cmWordT word, input bit chkSel,
                           input int hold, output time loadAt, output time writeAt);
    cmWordT  rd;
    bankSelT sel;
    sel = selOf(bankOf(addr, coreOvl, pmBoundarySel));
    hostXfer(LOAD_HIGH, addr, word[23:8], sel, chkSel, hold, rd, loadAt);
    hostXfer(WRITE_LOW, addr, {~word[23:16], word[7:0]}, sel, chkSel, hold, rd, writeAt);
  endtask

  task automatic hostWriteModel(input cmAddrT addr, input cmWordT word);
    time t1;
    time t2;
    hostWrite(addr, word, 1'b1, 0, t1, t2);
    modelWrite(addr, coreOvl, pmBoundarySel, word);
  endtask

  task automatic hostRead(input cmAddrT addr);
    cmWordT rd;
    time    t1;
    hostXfer(READ, addr, '0, selOf(bankOf(addr, coreOvl, pmBoundarySel)), 1'b1, 0, rd, t1);
    checkWord("hostRdata", modelRead(addr, coreOvl, pmBoundarySel), rd);
  endtask

  initial
  begin
    cmAddrT addr;
    cmAddrT hAddr;
    cmAddrT bAddr;
    cmWordT hWord;
    cmWordT bWord;
    ovlIdxT ovlA;
    ovlIdxT ovlB;
    ovlIdxT bOvl;
    time    tLoad;
    time    tWrite;
    time    tBoot;
    int     gapH;
    int     gapB;
    int     holdH;
    int     holdB;
    cmAddrT rbAddr [$];
    ovlIdxT rbOvl [$];
    DSPCLK        = 1'b0;
    rstN          = 1'b0;
    hostReq       = '0;
    hostReqValid  = 1'b0;
    bootReq       = '0;
    bootReqValid  = 1'b0;
    coreOvl       = '0;
    pmBoundarySel = 1'b0;
    repeat (4) @(posedge DSPCLK);
    #1;
    rstN = 1'b1;
    checkSel("cmSel", '0, cmSel);
    if (hostAck || bootAck)
    begin
      $display("An ack is high after reset");
      protoErrs++;
    end
    for (int m = 0; m < 2; m++)  // Base bank in both boundary modes
    begin
      pmBoundarySel = m[0];
      repeat (6)
      begin
        addr = pickAddr(0, pmBoundarySel);
        hostWriteModel(addr, cmWordT'($random(seed)));
        hostRead(addr);
      end
    end
    repeat (6)  // Same offset in two overlay banks
    begin
      pmBoundarySel = 1'($random(seed));
      addr = pickAddr(1, pmBoundarySel);
      ovlA = ovlIdxT'($random(seed) & 7);
      ovlB = ovlIdxT'((int'(ovlA) + 1 + ($random(seed) & 3)) & 7);
      coreOvl = ovlA;
      hostWriteModel(addr, cmWordT'($random(seed)));
      coreOvl = ovlB;
      hostWriteModel(addr, cmWordT'($random(seed)));
      hostRead(addr);
      coreOvl = ovlA;
      hostRead(addr);
    end
    repeat (6)  // Unmapped addresses and overlay indices
    begin
      pmBoundarySel = 1'($random(seed));
      coreOvl = ovlIdxT'($random(seed));
      addr = pickAddr(2, pmBoundarySel);
      hostWriteModel(addr, cmWordT'($random(seed)));
      hostRead(addr);
      coreOvl = ovlIdxT'(8 + ($random(seed) & 7));
      addr = pickAddr(1, pmBoundarySel);
      hostWriteModel(addr, cmWordT'($random(seed)));
      hostRead(addr);
    end
    repeat (6)  // Boot carries its own overlay
    begin
      pmBoundarySel = 1'($random(seed));
      addr = pickAddr(1, pmBoundarySel);
      ovlA = ovlIdxT'($random(seed) & 7);
      coreOvl = ovlIdxT'((int'(ovlA) + 3) & 7);
      bWord = cmWordT'($random(seed));
      bootXfer(addr, ovlA, bWord, selOf(bankOf(addr, ovlA, pmBoundarySel)), 1'b1, 0, tBoot);
      modelWrite(addr, ovlA, pmBoundarySel, bWord);
      coreOvl = ovlA;
      hostRead(addr);
    end
    pmBoundarySel = 1'($random(seed));
    coreOvl = ovlIdxT'($random(seed) & 7);
    repeat (12)  // Host and boot racing
    begin
      gapH  = $random(seed) & 3;
      gapB  = $random(seed) & 3;
      holdH = $random(seed) & 1;
      holdB = $random(seed) & 3;
      hAddr = pickAddr($random(seed) & 1, pmBoundarySel);
      bAddr = ($random(seed) & 1) ? hAddr : pickAddr($random(seed) & 1, pmBoundarySel);
      bOvl  = ($random(seed) & 1) ? coreOvl : ovlIdxT'($random(seed) & 7);
      hWord = cmWordT'($random(seed));
      bWord = cmWordT'($random(seed));
      fork
        begin
          repeat (gapH)
          begin
            @(posedge DSPCLK);
            #1;
          end
          hostWrite(hAddr, hWord, 1'b0, holdH, tLoad, tWrite);
        end
        begin
          repeat (gapB)
          begin
            @(posedge DSPCLK);
            #1;
          end
          bootXfer(bAddr, bOvl, bWord, '0, 1'b0, holdB, tBoot);
        end
      join
      if (gapH == gapB && tBoot > tLoad)
      begin
        $display("Boot was not granted first for simultaneous requests at %0t", $time);
        protoErrs++;
      end
      if (tBoot < tWrite)  // Apply in the order the writes completed
      begin
        modelWrite(bAddr, bOvl, pmBoundarySel, bWord);
        modelWrite(hAddr, coreOvl, pmBoundarySel, hWord);
      end
      else
      begin
        modelWrite(hAddr, coreOvl, pmBoundarySel, hWord);
        modelWrite(bAddr, bOvl, pmBoundarySel, bWord);
      end
      rbAddr.push_back(hAddr);
      rbOvl.push_back(coreOvl);
      rbAddr.push_back(bAddr);
      rbOvl.push_back(bOvl);
    end
    foreach (rbAddr[i])
    begin
      coreOvl = rbOvl[i];
      hostRead(rbAddr[i]);
    end
    printCounts();
    if (wordErrs + selErrs + protoErrs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/cmPkg.sv
logic/hostWordAssembler.sv
logic/overlaySelect.sv
logic/bankDecode.sv
logic/codeMemBanks.sv
logic/cmAccessCtrl.sv
logic/cmSubsystem.sv
tests/cmSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the code-memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module cmSubsystemTb -o simv
./obj_dir/simv > sim.log
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
